/* common/riscv_v_pkg.sv */
////////////////////////////////////////
// Vector geometry for the mask slice
// One mask bit per element, eight mask registers
////////////////////////////////////////
package riscv_v_pkg;

    // Elements per register, one mask bit each
    localparam int RISCV_V_NUM_ELEMENTS_REG = 32;

    // Mask register file depth
    localparam int RISCV_V_NUM_REGS = 8;

    // Index width, must cover RISCV_V_NUM_REGS
    localparam int RISCV_V_REG_ADDR_W = 3;

    // Whole mask register
    typedef logic [RISCV_V_NUM_ELEMENTS_REG-1:0] riscv_v_mask_reg_t;

    // Mask register index
    typedef logic [RISCV_V_REG_ADDR_W-1:0] riscv_v_reg_addr_t;

endpackage : riscv_v_pkg

/* common/riscv_v_mask_isa_pkg.sv */
////////////////////////////////////////
// OPMVV mask-logical encodings only
// Register fields are cut down to the mask file index
// The vm bit is not described here
////////////////////////////////////////
package riscv_v_mask_isa_pkg;

    localparam int RISCV_V_INST_W = 32;

    // Field positions in the instruction word
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_W   = 7;
    localparam int VD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_W   = 3;
    localparam int VS1_LSB    = 15;
    localparam int VS2_LSB    = 20;
    localparam int FUNCT6_LSB = 26;
    localparam int FUNCT6_W   = 6;

    // Major opcode OP-V and the OPMVV category
    localparam logic [OPCODE_W-1:0] OPCODE_OPV   = 7'b1010111;
    localparam logic [FUNCT3_W-1:0] FUNCT3_OPMVV = 3'b010;

    // Mask-logical funct6 codes
    localparam logic [FUNCT6_W-1:0] FUNCT6_VMANDN = 6'b011000;
    localparam logic [FUNCT6_W-1:0] FUNCT6_VMAND  = 6'b011001;
    localparam logic [FUNCT6_W-1:0] FUNCT6_VMOR   = 6'b011010;
    localparam logic [FUNCT6_W-1:0] FUNCT6_VMXOR  = 6'b011011;
    localparam logic [FUNCT6_W-1:0] FUNCT6_VMORN  = 6'b011100;
    localparam logic [FUNCT6_W-1:0] FUNCT6_VMNAND = 6'b011101;
    localparam logic [FUNCT6_W-1:0] FUNCT6_VMNOR  = 6'b011110;
    localparam logic [FUNCT6_W-1:0] FUNCT6_VMXNOR = 6'b011111;

    // Decoded controls for the mask ALU and the register file
    typedef struct packed {
        // Legal mask-logical instruction
        logic                           is_mask;
        // One-hot operation select
        logic                           is_and;
        logic                           is_or;
        logic                           is_xor;
        // vs1 inverted before the operation
        logic                           is_negate_srca;
        // Result inverted after the operation
        logic                           is_negate_result;
        riscv_v_pkg::riscv_v_reg_addr_t vd;
        riscv_v_pkg::riscv_v_reg_addr_t vs1;
        riscv_v_pkg::riscv_v_reg_addr_t vs2;
    } riscv_v_mask_ctrl_t;

endpackage : riscv_v_mask_isa_pkg

/* logic/riscv_v_mask_ALU.sv */
////////////////////////////////////////
// Purely combinational mask logic
// Operation strobes are expected one-hot
// Output is zero while is_mask is low
////////////////////////////////////////
`timescale 1ns/1ps

module riscv_v_mask_ALU (
    input  logic                           is_mask,
    input  logic                           is_and,
    input  logic                           is_or,
    input  logic                           is_xor,
    input  logic                           is_negate_srca,
    input  logic                           is_negate_result,
    input  riscv_v_pkg::riscv_v_mask_reg_t srca,
    input  riscv_v_pkg::riscv_v_mask_reg_t srcb,
    output riscv_v_pkg::riscv_v_mask_reg_t result
);
    import riscv_v_pkg::*;

    // Strobes widened to the full mask width
    riscv_v_mask_reg_t and_en;
    riscv_v_mask_reg_t or_en;
    riscv_v_mask_reg_t xor_en;

    riscv_v_mask_reg_t opa;
    riscv_v_mask_reg_t and_term;
    riscv_v_mask_reg_t or_term;
    riscv_v_mask_reg_t xor_term;
    riscv_v_mask_reg_t merged;
    riscv_v_mask_reg_t polarity;

    assign and_en = {RISCV_V_NUM_ELEMENTS_REG{is_and}};
    assign or_en  = {RISCV_V_NUM_ELEMENTS_REG{is_or}};
    assign xor_en = {RISCV_V_NUM_ELEMENTS_REG{is_xor}};

    // Inverting srca gives the andn/orn forms
    assign opa = srca ^ {RISCV_V_NUM_ELEMENTS_REG{is_negate_srca}};

    // Each term stays zero unless its strobe is set
    assign and_term = (opa & and_en) & srcb;
    assign or_term  = (opa & or_en) | (srcb & or_en);
    assign xor_term = (opa & xor_en) ^ (srcb & xor_en);

    // Only one term is live, so OR selects it
    assign merged = and_term | or_term | xor_term;

    // nand, nor and xnor
    assign polarity = merged ^ {RISCV_V_NUM_ELEMENTS_REG{is_negate_result}};

    assign result = polarity & {RISCV_V_NUM_ELEMENTS_REG{is_mask}};

endmodule : riscv_v_mask_ALU

/* logic/riscv_v_mask_regfile.sv */
////////////////////////////////////////
// Registered reads, one cycle after the address
// A write or load on the same edge is forwarded
// Result write and load must not coincide
////////////////////////////////////////
`timescale 1ns/1ps

module riscv_v_mask_regfile (
    input  logic                           clk,
    input  logic                           rst,
    input  riscv_v_pkg::riscv_v_reg_addr_t rd_addr_a,
    input  riscv_v_pkg::riscv_v_reg_addr_t rd_addr_b,
    output riscv_v_pkg::riscv_v_mask_reg_t rd_data_a,
    output riscv_v_pkg::riscv_v_mask_reg_t rd_data_b,
    input  logic                           wr_en,
    input  riscv_v_pkg::riscv_v_reg_addr_t wr_addr,
    input  riscv_v_pkg::riscv_v_mask_reg_t wr_data,
    input  logic                           load_valid,
    input  riscv_v_pkg::riscv_v_reg_addr_t load_addr,
    input  riscv_v_pkg::riscv_v_mask_reg_t load_data
);
    import riscv_v_pkg::*;

    riscv_v_mask_reg_t regs [RISCV_V_NUM_REGS];

    // Merged update port
    logic              upd_en;
    riscv_v_reg_addr_t upd_addr;
    riscv_v_mask_reg_t upd_data;

    // Stored value, or the value being written this edge
    function automatic riscv_v_mask_reg_t read_port(input riscv_v_reg_addr_t addr);
        riscv_v_mask_reg_t value;
        if (upd_en && (upd_addr == addr)) begin
            value = upd_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // Result writeback takes priority over the load port
    always_comb begin
        upd_en   = wr_en | load_valid;
        upd_addr = wr_en ? wr_addr : load_addr;
        upd_data = wr_en ? wr_data : load_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RISCV_V_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (upd_en) begin
            regs[upd_addr] <= upd_data;
        end
    end

    // Both read ports sample every cycle
    always_ff @(posedge clk) begin
        rd_data_a <= read_port(rd_addr_a);
        rd_data_b <= read_port(rd_addr_b);
    end

    // Environment loads never land on a writeback edge
    a_no_load_on_write: assert property (@(posedge clk) disable iff (rst)
        !(wr_en && load_valid))
        else $error("riscv_v_mask_regfile: load collides with result write");

endmodule : riscv_v_mask_regfile

/* logic/riscv_v_mask_decoder.sv */
////////////////////////////////////////
// Decodes only the eight mask-logical ops
// vd/vs1/vs2 use their low bits, vm is ignored
// Anything else comes out with is_mask low
////////////////////////////////////////
`timescale 1ns/1ps

module riscv_v_mask_decoder (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                inst_valid,
    input  logic [riscv_v_mask_isa_pkg::RISCV_V_INST_W-1:0]     inst,
    output logic                                                ctrl_valid,
    output riscv_v_mask_isa_pkg::riscv_v_mask_ctrl_t            ctrl
);
    import riscv_v_pkg::*;
    import riscv_v_mask_isa_pkg::*;

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT6_W-1:0] funct6;
    logic                is_opmvv;
    riscv_v_mask_ctrl_t  ctrl_d;

    assign opcode = inst[OPCODE_LSB +: OPCODE_W];
    assign funct3 = inst[FUNCT3_LSB +: FUNCT3_W];
    assign funct6 = inst[FUNCT6_LSB +: FUNCT6_W];

    assign is_opmvv = (opcode == OPCODE_OPV) && (funct3 == FUNCT3_OPMVV);

    always_comb begin
        ctrl_d     = '0;
        ctrl_d.vd  = inst[VD_LSB +: RISCV_V_REG_ADDR_W];
        ctrl_d.vs1 = inst[VS1_LSB +: RISCV_V_REG_ADDR_W];
        ctrl_d.vs2 = inst[VS2_LSB +: RISCV_V_REG_ADDR_W];

        if (is_opmvv) begin
            ctrl_d.is_mask = 1'b1;
            case (funct6)
                FUNCT6_VMAND: ctrl_d.is_and = 1'b1;
                FUNCT6_VMOR:  ctrl_d.is_or  = 1'b1;
                FUNCT6_VMXOR: ctrl_d.is_xor = 1'b1;
                // vs2 & ~vs1
                FUNCT6_VMANDN: begin
                    ctrl_d.is_and         = 1'b1;
                    ctrl_d.is_negate_srca = 1'b1;
                end
                // vs2 | ~vs1
                FUNCT6_VMORN: begin
                    ctrl_d.is_or          = 1'b1;
                    ctrl_d.is_negate_srca = 1'b1;
                end
                FUNCT6_VMNAND: begin
                    ctrl_d.is_and           = 1'b1;
                    ctrl_d.is_negate_result = 1'b1;
                end
                FUNCT6_VMNOR: begin
                    ctrl_d.is_or            = 1'b1;
                    ctrl_d.is_negate_result = 1'b1;
                end
                FUNCT6_VMXNOR: begin
                    ctrl_d.is_xor           = 1'b1;
                    ctrl_d.is_negate_result = 1'b1;
                end
                // Unknown funct6 inside OPMVV
                default: ctrl_d.is_mask = 1'b0;
            endcase
        end
    end

    // Controls hold their last value between issues
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_valid <= 1'b0;
            ctrl       <= '0;
        end else begin
            ctrl_valid <= inst_valid;
            if (inst_valid) begin
                ctrl <= ctrl_d;
            end
        end
    end

    // Exactly one operation strobe for every legal instruction
    a_op_onehot: assert property (@(posedge clk) disable iff (rst)
        ctrl_valid && ctrl.is_mask |-> $onehot({ctrl.is_and, ctrl.is_or, ctrl.is_xor}))
        else $error("riscv_v_mask_decoder: operation strobes not one-hot");

endmodule : riscv_v_mask_decoder

/* logic/riscv_v_mask_unit.sv */
////////////////////////////////////////
// Result shows 2 cycles after issue, written one edge later
// No back-pressure, one instruction per cycle
// Loads must avoid writeback edges
////////////////////////////////////////
`timescale 1ns/1ps

module riscv_v_mask_unit (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            inst_valid,
    input  logic [riscv_v_mask_isa_pkg::RISCV_V_INST_W-1:0] inst,
    input  logic                                            load_valid,
    input  riscv_v_pkg::riscv_v_reg_addr_t                  load_addr,
    input  riscv_v_pkg::riscv_v_mask_reg_t                  load_data,
    output logic                                            result_valid,
    output riscv_v_pkg::riscv_v_reg_addr_t                  result_vd,
    output riscv_v_pkg::riscv_v_mask_reg_t                  result,
    output logic                                            illegal
);
    import riscv_v_pkg::*;
    import riscv_v_mask_isa_pkg::*;

    logic               ctrl_valid;
    riscv_v_mask_ctrl_t ctrl;

    // Operand stage, aligned with the register file read data
    logic               stage_valid;
    riscv_v_mask_ctrl_t stage_ctrl;

    riscv_v_mask_reg_t  vs1_data;
    riscv_v_mask_reg_t  vs2_data;
    riscv_v_mask_reg_t  alu_result;
    logic               wb_en;

    riscv_v_mask_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl)
    );

    riscv_v_mask_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .rd_addr_a  (ctrl.vs1),
        .rd_addr_b  (ctrl.vs2),
        .rd_data_a  (vs1_data),
        .rd_data_b  (vs2_data),
        .wr_en      (wb_en),
        .wr_addr    (stage_ctrl.vd),
        .wr_data    (alu_result),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
            stage_ctrl  <= '0;
        end else begin
            stage_valid <= ctrl_valid;
            stage_ctrl  <= ctrl;
        end
    end

    // srca is vs1, so vmandn gives vs2 & ~vs1
    riscv_v_mask_ALU u_alu (
        .is_mask          (stage_ctrl.is_mask),
        .is_and           (stage_ctrl.is_and),
        .is_or            (stage_ctrl.is_or),
        .is_xor           (stage_ctrl.is_xor),
        .is_negate_srca   (stage_ctrl.is_negate_srca),
        .is_negate_result (stage_ctrl.is_negate_result),
        .srca             (vs1_data),
        .srcb             (vs2_data),
        .result           (alu_result)
    );

    assign result_valid = stage_valid;
    assign result_vd    = stage_ctrl.vd;
    assign result       = alu_result;
    assign illegal      = stage_valid & ~stage_ctrl.is_mask;

    // Illegal encodings never reach the register file
    assign wb_en = stage_valid & stage_ctrl.is_mask;

    a_illegal_zero: assert property (@(posedge clk) disable iff (rst)
        illegal |-> (result == '0))
        else $error("riscv_v_mask_unit: nonzero result on illegal instruction");

endmodule : riscv_v_mask_unit

/* dv/riscv_v_mask_unit_tb.sv */
////////////////////////////////////////
// Directed tests against a shadow register model
// Results are expected 2 cycles after issue
// Loads are kept clear of writeback edges
////////////////////////////////////////
`timescale 1ns/1ps

module riscv_v_mask_unit_tb;
    import riscv_v_pkg::*;
    import riscv_v_mask_isa_pkg::*;

    // Summed length of all tests in cycles
    localparam int TEST_CYCLES    = 80;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    localparam logic [FUNCT6_W-1:0] MASK_OPS [8] = '{
        FUNCT6_VMANDN, FUNCT6_VMAND, FUNCT6_VMOR, FUNCT6_VMXOR,
        FUNCT6_VMORN, FUNCT6_VMNAND, FUNCT6_VMNOR, FUNCT6_VMXNOR
    };

    logic                      clk;
    logic                      rst;
    logic                      inst_valid;
    logic [RISCV_V_INST_W-1:0] inst;
    logic                      load_valid;
    riscv_v_reg_addr_t         load_addr;
    riscv_v_mask_reg_t         load_data;
    logic                      result_valid;
    riscv_v_reg_addr_t         result_vd;
    riscv_v_mask_reg_t         result;
    logic                      illegal;

    // Shadow of the mask register file
    riscv_v_mask_reg_t shadow [RISCV_V_NUM_REGS];
    logic [31:0]       rng_state;
    int                cycle_count = 0;

    riscv_v_mask_unit u_riscv_v_mask_unit (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .result_valid (result_valid),
        .result_vd    (result_vd),
        .result       (result),
        .illegal      (illegal)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // OPMVV word with vm set and padded register fields
    function automatic logic [31:0] encode_inst(input logic [FUNCT6_W-1:0] funct6,
                                                input logic [FUNCT3_W-1:0] funct3,
                                                input riscv_v_reg_addr_t   vd,
                                                input riscv_v_reg_addr_t   vs1,
                                                input riscv_v_reg_addr_t   vs2);
        return {funct6, 1'b1, 2'b00, vs2, 2'b00, vs1, funct3, 2'b00, vd, OPCODE_OPV};
    endfunction

    // Mask-logical rules with vs2 as the left operand
    function automatic riscv_v_mask_reg_t expected_mask(input logic [FUNCT6_W-1:0] funct6,
                                                        input riscv_v_mask_reg_t   vs1_val,
                                                        input riscv_v_mask_reg_t   vs2_val);
        riscv_v_mask_reg_t value;
        case (funct6)
            FUNCT6_VMANDN: value = vs2_val & ~vs1_val;
            FUNCT6_VMAND:  value = vs2_val & vs1_val;
            FUNCT6_VMOR:   value = vs2_val | vs1_val;
            FUNCT6_VMXOR:  value = vs2_val ^ vs1_val;
            FUNCT6_VMORN:  value = vs2_val | ~vs1_val;
            FUNCT6_VMNAND: value = ~(vs2_val & vs1_val);
            FUNCT6_VMNOR:  value = ~(vs2_val | vs1_val);
            FUNCT6_VMXNOR: value = ~(vs2_val ^ vs1_val);
            default:       value = '0;
        endcase
        return value;
    endfunction

    task automatic wait_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp_value);
        assert (got === exp_value) else begin
            $display("ERR time=%0t %s got=%b exp=%b", $time, name, got, exp_value);
            $display("STATUS: FAIL");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_word(input string             name,
                              input riscv_v_mask_reg_t got,
                              input riscv_v_mask_reg_t exp_value);
        assert (got === exp_value) else begin
            $display("ERR time=%0t %s got=%h exp=%h", $time, name, got, exp_value);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_result(input riscv_v_reg_addr_t vd,
                                input riscv_v_mask_reg_t exp_value,
                                input logic              exp_illegal);
        check_bit("result_valid", result_valid, 1'b1);
        check_bit("illegal", illegal, exp_illegal);
        check_word("result_vd", {29'b0, result_vd}, {29'b0, vd});
        check_word("result", result, exp_value);
    endtask

    // No result pending on the outputs
    task automatic check_idle();
        check_bit("result_valid", result_valid, 1'b0);
        check_bit("illegal", illegal, 1'b0);
    endtask

    task automatic load_reg(input riscv_v_reg_addr_t addr, input riscv_v_mask_reg_t data);
        load_valid = 1'b1;
        load_addr  = addr;
        load_data  = data;
        wait_cycle();
        load_valid = 1'b0;
        shadow[addr] = data;
    endtask

    task automatic execute_op(input logic [FUNCT6_W-1:0] funct6,
                              input riscv_v_reg_addr_t   vd,
                              input riscv_v_reg_addr_t   vs1,
                              input riscv_v_reg_addr_t   vs2);
        riscv_v_mask_reg_t exp_value;
        exp_value  = expected_mask(funct6, shadow[vs1], shadow[vs2]);
        inst_valid = 1'b1;
        inst       = encode_inst(funct6, FUNCT3_OPMVV, vd, vs1, vs2);
        wait_cycle();
        inst_valid = 1'b0;
        wait_cycle();
        check_result(vd, exp_value, 1'b0);
        shadow[vd] = exp_value;
        // Writeback lands on this edge
        wait_cycle();
        check_idle();
    endtask

    task automatic expect_illegal(input logic [31:0] inst_word, input riscv_v_reg_addr_t vd);
        inst_valid = 1'b1;
        inst       = inst_word;
        wait_cycle();
        inst_valid = 1'b0;
        wait_cycle();
        check_result(vd, '0, 1'b1);
        wait_cycle();
        check_idle();
    endtask

    task automatic after_reset();
        check_idle();
        execute_op(FUNCT6_VMOR, 3'd0, 3'd1, 3'd2);
    endtask

    task automatic all_ops_random();
        for (int n = 0; n < 8; n++) begin
            rng_state = xorshift32(rng_state);
            load_reg(3'd1, rng_state);
            rng_state = xorshift32(rng_state);
            load_reg(3'd2, rng_state);
            execute_op(MASK_OPS[n], 3'd3, 3'd1, 3'd2);
        end
    endtask

    // Four dependent ops v4 = op(v5, v4) issued back to back
    task automatic dependent_chain();
        logic [FUNCT6_W-1:0] ops [4];
        riscv_v_mask_reg_t   exp_chain [4];
        riscv_v_mask_reg_t   running;
        ops = '{FUNCT6_VMXOR, FUNCT6_VMORN, FUNCT6_VMAND, FUNCT6_VMXNOR};
        rng_state = xorshift32(rng_state);
        load_reg(3'd4, rng_state);
        rng_state = xorshift32(rng_state);
        load_reg(3'd5, rng_state);
        running = shadow[4];
        for (int i = 0; i < 4; i++) begin
            running      = expected_mask(ops[i], running, shadow[5]);
            exp_chain[i] = running;
        end
        for (int i = 0; i < 6; i++) begin
            if (i >= 2) begin
                check_result(3'd4, exp_chain[i-2], 1'b0);
                shadow[4] = exp_chain[i-2];
            end
            if (i < 4) begin
                inst_valid = 1'b1;
                inst       = encode_inst(ops[i], FUNCT3_OPMVV, 3'd4, 3'd4, 3'd5);
            end else begin
                inst_valid = 1'b0;
            end
            wait_cycle();
        end
    endtask

    task automatic illegal_encodings();
        rng_state = xorshift32(rng_state);
        load_reg(3'd6, rng_state);
        // funct6 outside the mask group
        expect_illegal(encode_inst(FUNCT6_VMAND ^ 6'b100000, FUNCT3_OPMVV, 3'd6, 3'd1, 3'd2),
                       3'd6);
        // vmand funct6 under OPIVV
        expect_illegal(encode_inst(FUNCT6_VMAND, 3'b000, 3'd6, 3'd1, 3'd2), 3'd6);
        execute_op(FUNCT6_VMOR, 3'd7, 3'd6, 3'd6);
    endtask

    task automatic self_overwrite();
        execute_op(FUNCT6_VMXOR, 3'd2, 3'd2, 3'd2);
        execute_op(FUNCT6_VMXNOR, 3'd3, 3'd3, 3'd3);
        execute_op(FUNCT6_VMANDN, 3'd1, 3'd1, 3'd3);
        execute_op(FUNCT6_VMOR, 3'd0, 3'd2, 3'd3);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        rng_state  = 32'h4f4aabda;
        for (int i = 0; i < RISCV_V_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (2) wait_cycle();
        rst = 1'b0;

        after_reset();
        all_ops_random();
        dependent_chain();
        illegal_encodings();
        self_overwrite();

        $display("STATUS: PASS");
        $finish;
    end

endmodule : riscv_v_mask_unit_tb

/* compile.f */
common/riscv_v_pkg.sv
common/riscv_v_mask_isa_pkg.sv
logic/riscv_v_mask_ALU.sv
logic/riscv_v_mask_regfile.sv
logic/riscv_v_mask_decoder.sv
logic/riscv_v_mask_unit.sv
dv/riscv_v_mask_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the mask unit testbench with Verilator and runs it.
# Exits nonzero when the log reports a failure.
set -u

cd "$(dirname "$0")" || exit 1

TOP=riscv_v_mask_unit_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$TOP" -Mdir "$OBJ_DIR" -o "$TOP" -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "Simulation ended without a status line"
    exit 1
fi

exit 0
